// ==== spi_cmd_pkg.sv ====
// spi command set: opcodes, command classes and frame widths of the monitored bus
package spi_cmd_pkg;

    ////////////////////////////////////////////////////////////
    // frame geometry
    ////////////////////////////////////////////////////////////
    localparam int CMD_BITS   = 8;                      // opcode is the first byte on mosi
    localparam int ADDR_BITS  = 32;                     // the bus always runs 4-byte addressing
    localparam int FRAME_BITS = CMD_BITS + ADDR_BITS;   // nothing after the address matters here
    localparam int CNT_BITS   = $clog2(FRAME_BITS + 1); // bit counter saturates at FRAME_BITS

    ////////////////////////////////////////////////////////////
    // opcodes
    ////////////////////////////////////////////////////////////
    // reads, status and write-enable latch control are always let through
    localparam logic [CMD_BITS-1:0] OP_READ4B      = 8'h13;
    localparam logic [CMD_BITS-1:0] OP_FAST_READ4B = 8'h0C;
    localparam logic [CMD_BITS-1:0] OP_RDSR        = 8'h05;
    localparam logic [CMD_BITS-1:0] OP_RDID        = 8'h9F;
    localparam logic [CMD_BITS-1:0] OP_WREN        = 8'h06;
    localparam logic [CMD_BITS-1:0] OP_WRDI        = 8'h04;

    // program and erase only pass when their 4 kB sector is enabled
    localparam logic [CMD_BITS-1:0] OP_PP4B        = 8'h12;
    localparam logic [CMD_BITS-1:0] OP_SE4B        = 8'h21;

    // reason bit reported in the filtered-command record
    localparam logic REASON_SECTOR  = 1'b0;             // write or erase to a protected sector
    localparam logic REASON_ILLEGAL = 1'b1;             // opcode not on the list at all

    typedef enum logic [1:0] {
        CLS_ALLOWED = 2'd0,                             // passes untouched
        CLS_WRITE   = 2'd1,                             // decided once the address is in
        CLS_ILLEGAL = 2'd2                              // decided on the opcode alone
    } cmd_class_t;

endpackage

// ==== filter_cfg_pkg.sv ====
// filter configuration: flash geometry, write-enable mask sizing and apb register map
package filter_cfg_pkg;

    ////////////////////////////////////////////////////////////
    // flash and sector geometry
    ////////////////////////////////////////////////////////////
    localparam int FLASH_ADDR_BITS = 20;                // 1 MB part, upper address bits ignored
    localparam int SECTOR_BITS     = 12;                // 4 kB per write-enable bit
    localparam int SECTOR_IDX_BITS = FLASH_ADDR_BITS - SECTOR_BITS;

    typedef logic [SECTOR_IDX_BITS-1:0] sector_idx_t;   // address bits 19:12

    ////////////////////////////////////////////////////////////
    // write-enable mask
    ////////////////////////////////////////////////////////////
    localparam int MASK_WORD_BITS = 32;
    localparam int MASK_WORDS     = 8;                  // 8 x 32 bits covers all 256 sectors
    localparam int WORD_IDX_BITS  = $clog2(MASK_WORDS);     // sector bits 7:5 pick the word
    localparam int BIT_IDX_BITS   = $clog2(MASK_WORD_BITS); // sector bits 4:0 pick the bit
    localparam int BYTE_OFF_BITS  = $clog2(MASK_WORD_BITS / 8);
    localparam int MASK_SPAN      = MASK_WORDS * (MASK_WORD_BITS / 8); // bytes of address space

    ////////////////////////////////////////////////////////////
    // apb register map
    ////////////////////////////////////////////////////////////
    localparam int APB_ADDR_BITS = 6;
    localparam int APB_DATA_BITS = 32;

    localparam logic [APB_ADDR_BITS-1:0] REG_MASK_BASE   = 6'h00; // words at 0x00 to 0x1c
    localparam logic [APB_ADDR_BITS-1:0] REG_FILTER_INFO = 6'h20; // read only

    // filtered-command record layout
    localparam int INFO_ADDR_LSB   = 14;                // address bits 31:14 land in 31:14
    localparam int INFO_COUNT_BITS = 5;                 // count field sits in 12:8
    localparam int INFO_COUNT_MAX  = 31;

endpackage

// ==== spi_cmd_decode.sv ====
// spi frame decoder: oversamples the monitored bus and pulls out opcode and 32-bit address
`timescale 1ns/1ps

module spi_cmd_decode (
    input  wire                                 clock,
    input  wire                                 i_rst_n,
    input  wire                                 i_spi_sclk,     // host sclk, slow next to clock
    input  wire                                 i_spi_mosi,
    input  wire                                 i_spi_csn,
    output logic                                o_cmd_valid,    // one clock, opcode complete
    output logic [spi_cmd_pkg::CMD_BITS-1:0]    o_cmd,
    output logic                                o_addr_valid,   // one clock, address complete
    output logic [spi_cmd_pkg::ADDR_BITS-1:0]   o_addr,
    output logic                                o_frame_end     // one clock after csn goes high
);
    import spi_cmd_pkg::*;

    logic [2:0]           sclk_q;     // two sync stages plus last value for the edge
    logic [2:0]           csn_q;
    logic [1:0]           mosi_q;     // kept in step with sclk_q[1]
    logic                 sclk_rise;  // sampling edge inside a frame
    logic                 csn_rise;   // host has released the flash
    logic                 bit_take;   // this edge carries an opcode or address bit
    logic [CNT_BITS-1:0]  bit_cnt;    // bits taken in the current frame
    logic [ADDR_BITS-1:0] shift_q;
    logic [ADDR_BITS-1:0] shift_next;

    ////////////////////////////////////////////////////////////
    // pin sampling
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            sclk_q <= '0;
            csn_q  <= '1;                             // bus starts idle, no false frame end
            mosi_q <= '0;
        end else begin
            sclk_q <= {sclk_q[1:0], i_spi_sclk};
            csn_q  <= {csn_q[1:0], i_spi_csn};
            mosi_q <= {mosi_q[0], i_spi_mosi};
        end
    end

    assign sclk_rise  = sclk_q[1] & ~sclk_q[2] & ~csn_q[1]; // edges with csn high are ignored
    assign csn_rise   = csn_q[1] & ~csn_q[2];
    assign bit_take   = sclk_rise & (bit_cnt < CNT_BITS'(FRAME_BITS));
    assign shift_next = {shift_q[ADDR_BITS-2:0], mosi_q[1]}; // msb first

    ////////////////////////////////////////////////////////////
    // bit counter and strobes
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            bit_cnt      <= '0;
            o_cmd_valid  <= 1'b0;
            o_addr_valid <= 1'b0;
            o_frame_end  <= 1'b0;
        end else begin
            o_cmd_valid  <= bit_take & (bit_cnt == CNT_BITS'(CMD_BITS - 1));
            o_addr_valid <= bit_take & (bit_cnt == CNT_BITS'(FRAME_BITS - 1));
            o_frame_end  <= csn_rise;
            if (csn_rise) begin
                bit_cnt <= '0;                        // ready for the next frame
            end else if (bit_take) begin
                bit_cnt <= bit_cnt + 1'b1;
            end
        end
    end

    // data path, frozen once the address is in so o_addr holds for the policy
    always_ff @(posedge clock) begin
        if (bit_take) begin
            shift_q <= shift_next;
        end
        if (bit_take && bit_cnt == CNT_BITS'(CMD_BITS - 1)) begin
            o_cmd <= shift_next[CMD_BITS-1:0];        // opcode would shift out under the address
        end
    end

    assign o_addr = shift_q;

endmodule

// ==== spi_cmd_policy.sv ====
// command policy: classifies opcodes, checks sector write enables and raises the csn block
`timescale 1ns/1ps

module spi_cmd_policy (
    input  wire                                 clock,
    input  wire                                 i_rst_n,
    input  wire                                 i_filter_disable,   // permissive mode
    input  wire                                 i_cmd_valid,
    input  wire  [spi_cmd_pkg::CMD_BITS-1:0]    i_cmd,
    input  wire                                 i_addr_valid,
    input  wire  [spi_cmd_pkg::ADDR_BITS-1:0]   i_addr,
    input  wire                                 i_frame_end,
    input  wire                                 i_sector_we,        // mask bit for o_sector
    output filter_cfg_pkg::sector_idx_t         o_sector,
    output logic                                o_block,            // holds csn high to the flash
    output logic                                o_block_event,
    output logic                                o_block_reason,
    output logic [spi_cmd_pkg::CMD_BITS-1:0]    o_cmd,
    output logic [spi_cmd_pkg::ADDR_BITS-1:0]   o_addr              // zero for illegal opcodes
);
    import spi_cmd_pkg::*;
    import filter_cfg_pkg::*;

    cmd_class_t cls_now;    // class of the opcode on i_cmd
    cmd_class_t cls_q;      // class of the command in flight
    logic       blk_cmd;    // illegal opcode, decided on the opcode
    logic       blk_addr;   // protected sector, decided on the address

    always_comb begin
        case (i_cmd)
            OP_READ4B, OP_FAST_READ4B, OP_RDSR,
            OP_RDID, OP_WREN, OP_WRDI: cls_now = CLS_ALLOWED;
            OP_PP4B, OP_SE4B:          cls_now = CLS_WRITE;
            default:                   cls_now = CLS_ILLEGAL;
        endcase
    end

    // sector lookup is combinational so the decision lands on the addr_valid edge
    assign o_sector = i_addr[FLASH_ADDR_BITS-1:SECTOR_BITS];
    assign blk_cmd  = i_cmd_valid & (cls_now == CLS_ILLEGAL) & ~i_filter_disable;
    assign blk_addr = i_addr_valid & (cls_q == CLS_WRITE) & ~i_sector_we & ~i_filter_disable;

    ////////////////////////////////////////////////////////////
    // block flag
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            cls_q          <= CLS_ALLOWED;
            o_block        <= 1'b0;
            o_block_event  <= 1'b0;
            o_block_reason <= REASON_SECTOR;
        end else begin
            o_block_event <= blk_cmd | blk_addr;      // same edge the flag sets
            if (i_frame_end) begin
                cls_q   <= CLS_ALLOWED;
                o_block <= 1'b0;                      // host released csn, let the next frame go
            end else begin
                if (i_cmd_valid) begin
                    cls_q <= cls_now;
                end
                if (blk_cmd | blk_addr) begin
                    o_block <= 1'b1;
                end
            end
            if (blk_cmd | blk_addr) begin
                o_block_reason <= blk_cmd ? REASON_ILLEGAL : REASON_SECTOR;
            end
        end
    end

    // record payload for the log, valid while o_block_event is high
    always_ff @(posedge clock) begin
        if (i_cmd_valid) begin
            o_cmd <= i_cmd;
        end
        if (blk_cmd) begin
            o_addr <= '0;                             // no address has been sent yet
        end else if (blk_addr) begin
            o_addr <= i_addr;
        end
    end

endmodule

// ==== we_mask_regs.sv ====
// apb slave for the sector write-enable bitmap, with read-back of the filter record
`timescale 1ns/1ps

module we_mask_regs (
    input  wire                                         clock,
    input  wire                                         i_rst_n,
    input  wire                                         i_psel,
    input  wire                                         i_penable,
    input  wire                                         i_pwrite,
    input  wire  [filter_cfg_pkg::APB_ADDR_BITS-1:0]    i_paddr,
    input  wire  [filter_cfg_pkg::APB_DATA_BITS-1:0]    i_pwdata,
    input  filter_cfg_pkg::sector_idx_t                 i_sector,       // from the policy
    input  wire  [filter_cfg_pkg::APB_DATA_BITS-1:0]    i_filter_info,
    output logic [filter_cfg_pkg::APB_DATA_BITS-1:0]    o_prdata,
    output logic                                        o_pready,
    output logic                                        o_pslverr,
    output logic                                        o_sector_we     // 1 = sector may be written
);
    import filter_cfg_pkg::*;

    logic [MASK_WORD_BITS-1:0] mask_q [MASK_WORDS];   // one bit per 4 kB sector
    logic                      access;                // apb access phase
    logic                      is_mask;
    logic                      is_info;
    logic [APB_ADDR_BITS-1:0]  mask_off;              // byte offset into the mask window
    logic [WORD_IDX_BITS-1:0]  word_idx;

    ////////////////////////////////////////////////////////////
    // address decode
    ////////////////////////////////////////////////////////////
    assign access   = i_psel & i_penable;
    assign mask_off = i_paddr - REG_MASK_BASE;        // wraps high below the base
    assign is_mask  = (mask_off < MASK_SPAN);
    assign is_info  = (i_paddr == REG_FILTER_INFO);
    assign word_idx = mask_off[BYTE_OFF_BITS +: WORD_IDX_BITS];

    assign o_pready = 1'b1;                           // every access finishes in one cycle

    // unmapped addresses and writes to the read-only record are errors
    assign o_pslverr = access & ~is_mask & (~is_info | i_pwrite);

    always_comb begin
        if (is_mask) begin
            o_prdata = mask_q[word_idx];
        end else if (is_info) begin
            o_prdata = i_filter_info;
        end else begin
            o_prdata = '0;
        end
    end

    ////////////////////////////////////////////////////////////
    // mask storage
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < MASK_WORDS; i++) begin
                mask_q[i] <= '0;                      // every sector protected out of reset
            end
        end else if (access && i_pwrite && is_mask) begin
            mask_q[word_idx] <= i_pwdata;
        end
    end

    // sector 7:5 picks the word and 4:0 the bit inside it
    assign o_sector_we = mask_q[i_sector[SECTOR_IDX_BITS-1 -: WORD_IDX_BITS]]
                               [i_sector[BIT_IDX_BITS-1:0]];

endmodule

// ==== spi_filter_log.sv ====
// filtered-command record: last blocked opcode, its address, the reason and a saturating count
`timescale 1ns/1ps

module spi_filter_log (
    input  wire                                         clock,
    input  wire                                         i_rst_n,
    input  wire                                         i_block_event,
    input  wire                                         i_block_reason,
    input  wire  [spi_cmd_pkg::CMD_BITS-1:0]            i_cmd,
    input  wire  [spi_cmd_pkg::ADDR_BITS-1:0]           i_addr,
    output logic [filter_cfg_pkg::APB_DATA_BITS-1:0]    o_filter_info
);
    import spi_cmd_pkg::*;
    import filter_cfg_pkg::*;

    logic [INFO_COUNT_BITS-1:0] count_q;    // count field of the current record
    logic [INFO_COUNT_BITS-1:0] count_next;

    assign count_q    = o_filter_info[CMD_BITS +: INFO_COUNT_BITS];
    assign count_next = (count_q == INFO_COUNT_BITS'(INFO_COUNT_MAX)) ? count_q
                                                                     : count_q + 1'b1;

    // layout is {addr 31:14, reason, count, opcode}
    always_ff @(posedge clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_filter_info <= '0;
        end else if (i_block_event) begin
            o_filter_info <= {i_addr[ADDR_BITS-1:INFO_ADDR_LSB], i_block_reason,
                              count_next, i_cmd};
        end
    end

endmodule

// ==== spi_filter_top.sv ====
// spi flash command filter top: decode, policy, mask registers, log and the csn gate
`timescale 1ns/1ps

module spi_filter_top (
    input  wire                                         clock,
    input  wire                                         i_rst_n,
    input  wire                                         i_filter_disable,   // 1 lets everything through
    input  wire                                         i_psel,
    input  wire                                         i_penable,
    input  wire                                         i_pwrite,
    input  wire  [filter_cfg_pkg::APB_ADDR_BITS-1:0]    i_paddr,
    input  wire  [filter_cfg_pkg::APB_DATA_BITS-1:0]    i_pwdata,
    input  wire                                         i_spi_sclk,         // monitored host bus
    input  wire                                         i_spi_mosi,
    input  wire                                         i_spi_csn,
    output logic [filter_cfg_pkg::APB_DATA_BITS-1:0]    o_prdata,
    output logic                                        o_pready,
    output logic                                        o_pslverr,
    output logic                                        o_spi_csn           // to the flash
);
    import spi_cmd_pkg::*;
    import filter_cfg_pkg::*;

    logic                     cmd_valid;
    logic [CMD_BITS-1:0]      cmd;
    logic                     addr_valid;
    logic [ADDR_BITS-1:0]     addr;
    logic                     frame_end;
    sector_idx_t              sector;
    logic                     sector_we;
    logic                     block;                  // registered, so no glitch reaches csn
    logic                     block_event;
    logic                     block_reason;
    logic [CMD_BITS-1:0]      log_cmd;
    logic [ADDR_BITS-1:0]     log_addr;
    logic [APB_DATA_BITS-1:0] filter_info;

    spi_cmd_decode u_decode (
        .clock          (clock),
        .i_rst_n        (i_rst_n),
        .i_spi_sclk     (i_spi_sclk),
        .i_spi_mosi     (i_spi_mosi),
        .i_spi_csn      (i_spi_csn),
        .o_cmd_valid    (cmd_valid),
        .o_cmd          (cmd),
        .o_addr_valid   (addr_valid),
        .o_addr         (addr),
        .o_frame_end    (frame_end)
    );

    spi_cmd_policy u_policy (
        .clock            (clock),
        .i_rst_n          (i_rst_n),
        .i_filter_disable (i_filter_disable),
        .i_cmd_valid      (cmd_valid),
        .i_cmd            (cmd),
        .i_addr_valid     (addr_valid),
        .i_addr           (addr),
        .i_frame_end      (frame_end),
        .i_sector_we      (sector_we),
        .o_sector         (sector),
        .o_block          (block),
        .o_block_event    (block_event),
        .o_block_reason   (block_reason),
        .o_cmd            (log_cmd),
        .o_addr           (log_addr)
    );

    we_mask_regs u_regs (
        .clock          (clock),
        .i_rst_n        (i_rst_n),
        .i_psel         (i_psel),
        .i_penable      (i_penable),
        .i_pwrite       (i_pwrite),
        .i_paddr        (i_paddr),
        .i_pwdata       (i_pwdata),
        .i_sector       (sector),
        .i_filter_info  (filter_info),
        .o_prdata       (o_prdata),
        .o_pready       (o_pready),
        .o_pslverr      (o_pslverr),
        .o_sector_we    (sector_we)
    );

    spi_filter_log u_log (
        .clock          (clock),
        .i_rst_n        (i_rst_n),
        .i_block_event  (block_event),
        .i_block_reason (block_reason),
        .i_cmd          (log_cmd),
        .i_addr         (log_addr),
        .o_filter_info  (filter_info)
    );

    // the host csn passes through until a block, then the flash sees it high
    assign o_spi_csn = i_spi_csn | block;

endmodule

// ==== tb_spi_filter_checker.sv ====
// testbench checker that mirrors the mask and the filter record and compares the dut responses
`timescale 1ns/1ps

module tb_spi_filter_checker (
    input  wire          clock,
    input  wire          i_rst_n,
    input  wire          i_filter_disable,
    input  wire          i_psel,
    input  wire          i_penable,
    input  wire          i_pwrite,
    input  wire  [5:0]   i_paddr,
    input  wire  [31:0]  i_pwdata,
    input  wire  [31:0]  i_prdata,
    input  wire          i_pready,
    input  wire          i_pslverr,
    input  wire          i_spi_sclk,
    input  wire          i_spi_mosi,
    input  wire          i_spi_csn,
    input  wire          i_flash_csn,    // dut csn toward the flash
    input  wire  [127:0] i_test_name,    // packed string of the running test
    output logic [31:0]  o_errors
);
    logic [31:0] mask [8];               // mirror of the write-enable words
    logic [31:0] info;                   // expected filtered-command record
    logic [39:0] frame;                  // opcode then address with the msb first
    int          nbits;
    logic        blocked;                // flash csn should be forced high
    logic        is_write;
    logic        sclk_prev;
    logic [1:0]  kind;
    logic        exp_err;
    logic [31:0] exp_rd;

    // 0 passes, 1 needs the sector bit, 2 is never allowed
    function automatic logic [1:0] opcode_kind(input logic [7:0] op);
        case (op)
            8'h13, 8'h0C, 8'h05, 8'h9F, 8'h06, 8'h04: opcode_kind = 2'd0;
            8'h12, 8'h21:                             opcode_kind = 2'd1;
            default:                                  opcode_kind = 2'd2;
        endcase
    endfunction

    task automatic record_block(input logic reason, input logic [31:0] addr,
                                input logic [7:0] op);
        logic [4:0] cnt;
        cnt = info[12:8];
        if (cnt != 5'd31) begin
            cnt = cnt + 5'd1;            // the count sticks at 31
        end
        info    = {addr[31:14], reason, cnt, op};
        blocked = 1'b1;
    endtask

    ////////////////////////////////////////////////////////////
    // spi frame model and csn comparison
    ////////////////////////////////////////////////////////////
    always @(posedge clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < 8; i++) begin
                mask[i] = '0;
            end
            info      = '0;
            frame     = '0;
            nbits     = 0;
            blocked   = 1'b0;
            is_write  = 1'b0;
            sclk_prev = 1'b0;
            o_errors  = '0;
        end else begin
            if (i_spi_csn) begin
                nbits    = 0;                // host released the flash so the next frame starts clean
                blocked  = 1'b0;
                is_write = 1'b0;
            end else if (i_spi_sclk && !sclk_prev) begin
                if (i_flash_csn !== blocked) begin
                    $display("Fail %0s: flash csn at bit %0d expected %b actual %b",
                             i_test_name, nbits + 1, blocked, i_flash_csn);
                    o_errors = o_errors + 1;
                end
                if (nbits < 40) begin
                    frame = {frame[38:0], i_spi_mosi};
                    nbits = nbits + 1;
                    if (nbits == 8) begin
                        kind     = opcode_kind(frame[7:0]);
                        is_write = (kind == 2'd1);
                        if (kind == 2'd2 && !i_filter_disable) begin
                            record_block(1'b1, 32'd0, frame[7:0]);
                        end
                    end else if (nbits == 40 && is_write && !i_filter_disable &&
                                 !mask[frame[19:17]][frame[16:12]]) begin
                        record_block(1'b0, frame[31:0], frame[39:32]); // protected sector
                    end
                end
            end
            sclk_prev = i_spi_sclk;

            ////////////////////////////////////////////////////////////
            // apb access phase
            ////////////////////////////////////////////////////////////
            if (i_psel && i_penable) begin
                exp_err = !(i_paddr < 6'h20 || (i_paddr == 6'h20 && !i_pwrite));
                if (i_pready !== 1'b1) begin
                    $display("Fail %0s: pready expected 1 actual %b", i_test_name, i_pready);
                    o_errors = o_errors + 1;
                end
                if (i_pslverr !== exp_err) begin
                    $display("Fail %0s: pslverr at 0x%02h expected %b actual %b",
                             i_test_name, i_paddr, exp_err, i_pslverr);
                    o_errors = o_errors + 1;
                end
                if (!exp_err && !i_pwrite) begin
                    exp_rd = (i_paddr == 6'h20) ? info : mask[i_paddr[4:2]];
                    if (i_prdata !== exp_rd) begin
                        $display("Fail %0s: prdata at 0x%02h expected 0x%08h actual 0x%08h",
                                 i_test_name, i_paddr, exp_rd, i_prdata);
                        o_errors = o_errors + 1;
                    end
                end
                if (!exp_err && i_pwrite) begin
                    mask[i_paddr[4:2]] = i_pwdata; // word index is the byte address over 4
                end
            end
        end
    end

endmodule

// ==== tb_spi_filter.sv ====
// testbench for the spi flash command filter that drives lfsr stimulus over apb and the spi bus
`timescale 1ns/1ps

module tb_spi_filter;

    localparam logic [47:0] ALLOWED_OPS  = 48'h13_0C_05_9F_06_04;
    localparam int FRAME_CYCLES   = 48 * 6 + 12;  // 48 bits of 6 clocks plus setup and gap
    localparam int APB_CYCLES     = 2;
    localparam int N_FRAMES       = 64;
    localparam int N_APB          = 39;
    localparam int TIMEOUT_CYCLES = 2 * (N_FRAMES * FRAME_CYCLES + N_APB * APB_CYCLES);

    logic         clock;
    logic         rst_n;
    logic         filter_disable;
    logic         psel;
    logic         penable;
    logic         pwrite;
    logic [5:0]   paddr;
    logic [31:0]  pwdata;
    logic [31:0]  prdata;
    logic         pready;
    logic         pslverr;
    logic         spi_sclk;
    logic         spi_mosi;
    logic         spi_csn;
    logic         flash_csn;
    logic [127:0] test_name;
    logic [31:0]  errors;        // running count from the checker
    logic [31:0]  err_start;
    logic [15:0]  lfsr;
    logic [7:0]   op;
    logic [31:0]  addr;
    logic [31:0]  r;
    int           tests_run;
    int           tests_failed;
    int           cycles;

    spi_filter_top u_dut (
        .clock            (clock),
        .i_rst_n          (rst_n),
        .i_filter_disable (filter_disable),
        .i_psel           (psel),
        .i_penable        (penable),
        .i_pwrite         (pwrite),
        .i_paddr          (paddr),
        .i_pwdata         (pwdata),
        .i_spi_sclk       (spi_sclk),
        .i_spi_mosi       (spi_mosi),
        .i_spi_csn        (spi_csn),
        .o_prdata         (prdata),
        .o_pready         (pready),
        .o_pslverr        (pslverr),
        .o_spi_csn        (flash_csn)
    );

    tb_spi_filter_checker u_checker (
        .clock            (clock),
        .i_rst_n          (rst_n),
        .i_filter_disable (filter_disable),
        .i_psel           (psel),
        .i_penable        (penable),
        .i_pwrite         (pwrite),
        .i_paddr          (paddr),
        .i_pwdata         (pwdata),
        .i_prdata         (prdata),
        .i_pready         (pready),
        .i_pslverr        (pslverr),
        .i_spi_sclk       (spi_sclk),
        .i_spi_mosi       (spi_mosi),
        .i_spi_csn        (spi_csn),
        .i_flash_csn      (flash_csn),
        .i_test_name      (test_name),
        .o_errors         (errors)
    );

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        lfsr_step = {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v    = {v[30:0], lfsr[0]};           // one step per bit taken
        end
    endtask

    task automatic wait_clocks(input int n);
        repeat (n) begin
            @(posedge clock);
            #2;                                  // inputs move just after the edge
        end
    endtask

    ////////////////////////////////////////////////////////////
    // bus drivers
    ////////////////////////////////////////////////////////////
    task automatic apb_access(input logic wr, input logic [5:0] a, input logic [31:0] d);
        psel    = 1'b1;
        pwrite  = wr;
        paddr   = a;
        pwdata  = d;
        penable = 1'b0;
        wait_clocks(1);
        penable = 1'b1;                          // the access phase is never stretched
        wait_clocks(1);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic send_frame(input logic [7:0] opcode, input logic [31:0] a);
        logic [47:0] bits;
        bits    = {opcode, a, 8'h00};            // trailing byte stands in for data
        spi_csn = 1'b0;
        for (int i = 47; i >= 0; i--) begin
            spi_mosi = bits[i];
            wait_clocks(3);
            spi_sclk = 1'b1;
            wait_clocks(3);
            spi_sclk = 1'b0;
        end
        wait_clocks(3);
        spi_csn = 1'b1;
        wait_clocks(6);                          // lets the block flag drop before the next frame
    endtask

    task automatic pick_allowed(output logic [7:0] opcode);
        logic [31:0] idx;
        idx = 32'd7;
        while (idx >= 6) begin
            draw_bits(3, idx);
        end
        opcode = ALLOWED_OPS[idx*8 +: 8];
    endtask

    task automatic pick_illegal(output logic [7:0] opcode);
        logic [31:0] v;
        logic        listed;
        listed = 1'b1;
        while (listed) begin
            draw_bits(8, v);
            opcode = v[7:0];
            listed = (opcode == 8'h12) || (opcode == 8'h21);
            for (int i = 0; i < 6; i++) begin
                listed = listed | (opcode == ALLOWED_OPS[i*8 +: 8]);
            end
        end
    endtask

    task automatic pick_write(output logic [7:0] opcode);
        logic [31:0] v;
        draw_bits(1, v);
        opcode = v[0] ? 8'h21 : 8'h12;           // sector erase or page program
    endtask

    task automatic start_test(input logic [127:0] name);
        test_name = name;
        err_start = errors;
    endtask

    task automatic end_test;
        tests_run = tests_run + 1;
        if (errors == err_start) begin
            $display("test %0s: ok", test_name);
        end else begin
            tests_failed = tests_failed + 1;
            $display("test %0s: failed with %0d errors", test_name, errors - err_start);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////
    initial begin
        rst_n          = 1'b0;
        filter_disable = 1'b0;
        psel           = 1'b0;
        penable        = 1'b0;
        pwrite         = 1'b0;
        paddr          = '0;
        pwdata         = '0;
        spi_sclk       = 1'b0;
        spi_mosi       = 1'b0;
        spi_csn        = 1'b1;                   // the monitored bus starts idle
        lfsr           = 16'd65;
        tests_run      = 0;
        tests_failed   = 0;
        test_name      = "reset";
        repeat (4) @(posedge clock);
        #2 rst_n = 1'b1;
        wait_clocks(2);

        start_test("allowed");
        repeat (6) begin
            pick_allowed(op);
            draw_bits(32, addr);
            send_frame(op, addr);
        end
        end_test();

        start_test("illegal");
        repeat (6) begin
            pick_illegal(op);
            draw_bits(32, addr);
            send_frame(op, addr);
            apb_access(1'b0, 6'h20, '0);         // record after every block
        end
        end_test();

        start_test("write_mask");
        for (int i = 0; i < 8; i++) begin
            draw_bits(32, r);
            apb_access(1'b1, 6'(i * 4), r);
        end
        repeat (12) begin
            pick_write(op);
            draw_bits(32, addr);
            send_frame(op, addr);
            apb_access(1'b0, 6'h20, '0);
        end
        end_test();

        start_test("permissive");
        filter_disable = 1'b1;
        repeat (4) begin
            pick_illegal(op);
            draw_bits(32, addr);
            send_frame(op, addr);
        end
        repeat (4) begin
            pick_write(op);
            draw_bits(32, addr);
            send_frame(op, addr);
        end
        filter_disable = 1'b0;
        apb_access(1'b0, 6'h20, '0);             // record must be untouched
        end_test();

        start_test("apb");
        for (int i = 0; i < 8; i++) begin
            apb_access(1'b0, 6'(i * 4), '0);
        end
        apb_access(1'b1, 6'h20, 32'hffff_ffff);
        apb_access(1'b0, 6'h24, '0);
        apb_access(1'b1, 6'h24, 32'h1234_5678);
        repeat (32) begin
            pick_illegal(op);
            draw_bits(32, addr);
            send_frame(op, addr);
        end
        apb_access(1'b0, 6'h20, '0);             // count has run into its ceiling
        end_test();

        $display("summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    initial cycles = 0;

    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("RESULT: FAIL");
            $finish;
        end
    end

endmodule

// ==== vlog.f ====
spi_cmd_pkg.sv
filter_cfg_pkg.sv
spi_cmd_decode.sv
spi_cmd_policy.sv
we_mask_regs.sv
spi_filter_log.sv
spi_filter_top.sv
tb_spi_filter_checker.sv
tb_spi_filter.sv
